// ==== hw/conv_geom_pkg.sv ====
package conv_geom_pkg;

  ////////////////////////////////////////////////////////////
  // Image geometry
  ////////////////////////////////////////////////////////////

  localparam int IMG_W  = 4;
  localparam int IMG_H  = 4;
  localparam int PIXELS = IMG_W * IMG_H;

  ////////////////////////////////////////////////////////////
  // Channels and weight store
  ////////////////////////////////////////////////////////////

  localparam int CH_IN   = 4;
  localparam int CH_OUT  = 4;
  localparam int WEIGHTS = CH_OUT * CH_IN;

  // One index width covers both channel counters
  localparam int CH_IDX_W = (CH_IN > CH_OUT) ? $clog2(CH_IN) : $clog2(CH_OUT);

  // Weight address is out_ch * CH_IN + in_ch
  localparam int WADDR_W = $clog2(WEIGHTS);

  // Input and output FIFOs
  localparam int FIFO_DEPTH = 4;

endpackage

// ==== hw/conv_num_pkg.sv ====
package conv_num_pkg;

  // Word widths
  localparam int PIXEL_W  = 8;
  localparam int WEIGHT_W = 8;
  localparam int ACC_W    = 20;
  localparam int RESULT_W = 16;

  typedef logic signed [PIXEL_W-1:0]  pixel_t;
  typedef logic signed [WEIGHT_W-1:0] weight_t;
  typedef logic signed [ACC_W-1:0]    acc_t;
  typedef logic signed [RESULT_W-1:0] result_t;

  // Arithmetic shift before the result is clamped
  localparam int OUT_SHIFT = 4;

  // Saturation limits, held at accumulator width for the compare
  localparam acc_t RES_MAX = acc_t'((2 ** (RESULT_W - 1)) - 1);
  localparam acc_t RES_MIN = acc_t'(-(2 ** (RESULT_W - 1)));

endpackage

// ==== hw/stream_fifo.sv ====
module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage, no reset needed on the payload
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at DEPTH, so any depth works
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hw/weight_store.sv ====
module weight_store
  import conv_geom_pkg::*;
  import conv_num_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                weight_valid,
  input  weight_t             weight_data,
  output logic                loaded,
  input  logic [CH_IDX_W-1:0] out_ch,
  input  logic [CH_IDX_W-1:0] in_ch,
  output weight_t             rd_weight
);

  weight_t            mem [WEIGHTS];
  logic [WADDR_W-1:0] wr_addr;
  logic [WADDR_W-1:0] rd_addr;
  logic               wr_en;

  // Weights arrive output-channel major, so a plain counter lands them in place
  assign wr_en = weight_valid & ~loaded;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= weight_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= '0;
      loaded  <= 1'b0;
    end else if (wr_en) begin
      wr_addr <= wr_addr + 1'b1;
      // Last word written, store is full until the next reset
      if (wr_addr == WADDR_W'(WEIGHTS - 1)) begin
        loaded <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Combinational read for the replay side
  ////////////////////////////////////////////////////////////

  assign rd_addr   = WADDR_W'(out_ch) * WADDR_W'(CH_IN) + WADDR_W'(in_ch);
  assign rd_weight = mem[rd_addr];

endmodule

// ==== hw/channel_replay.sv ====
module channel_replay
  import conv_geom_pkg::*;
  import conv_num_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic                loaded,
  input  logic                in_valid,
  output logic                in_ready,
  input  pixel_t              in_data,
  output logic [CH_IDX_W-1:0] out_ch,
  output logic [CH_IDX_W-1:0] in_ch,
  input  weight_t             rd_weight,
  output logic                rep_valid,
  input  logic                rep_ready,
  output pixel_t              rep_pixel,
  output weight_t             rep_weight,
  output logic                rep_last
);

  typedef enum logic {
    st_fill,
    st_replay
  } state_t;

  state_t              state;
  pixel_t              pix_buf [CH_IN];
  logic [CH_IDX_W-1:0] fill_idx;
  logic                take;
  logic                step;

  // Only one pixel held at a time, and only once weights are in
  assign in_ready = loaded & (state == st_fill);
  assign take     = in_valid & in_ready;

  assign rep_valid  = (state == st_replay);
  assign rep_pixel  = pix_buf[in_ch];
  assign rep_weight = rd_weight;
  assign rep_last   = (in_ch == CH_IDX_W'(CH_IN - 1));
  assign step       = rep_valid & rep_ready;

  always_ff @(posedge clk) begin
    if (take) begin
      pix_buf[fill_idx] <= in_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Fill, then replay all channels once per output channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_fill;
      fill_idx <= '0;
      out_ch   <= '0;
      in_ch    <= '0;
    end else begin
      case (state)
        st_fill: begin
          if (take) begin
            fill_idx <= fill_idx + 1'b1;
            if (fill_idx == CH_IDX_W'(CH_IN - 1)) begin
              fill_idx <= '0;
              out_ch   <= '0;
              in_ch    <= '0;
              state    <= st_replay;
            end
          end
        end
        st_replay: begin
          if (step) begin
            in_ch <= in_ch + 1'b1;
            if (rep_last) begin
              in_ch  <= '0;
              out_ch <= out_ch + 1'b1;
              // Final beat of the pixel
              if (out_ch == CH_IDX_W'(CH_OUT - 1)) begin
                out_ch <= '0;
                state  <= st_fill;
              end
            end
          end
        end
        default: state <= st_fill;
      endcase
    end
  end

endmodule

// ==== hw/mac_accumulator.sv ====
module mac_accumulator
  import conv_num_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    rep_valid,
  output logic    rep_ready,
  input  pixel_t  rep_pixel,
  input  weight_t rep_weight,
  input  logic    rep_last,
  output logic    res_valid,
  input  logic    res_ready,
  output result_t res_data
);

  logic    advance;
  logic    s1_valid;
  logic    s1_last;
  acc_t    s1_prod;
  acc_t    acc_q;
  acc_t    acc_sum;
  acc_t    acc_shift;
  result_t sat_res;

  // Whole pipe stalls while a result waits to be taken
  assign advance   = ~res_valid | res_ready;
  assign rep_ready = advance;

  ////////////////////////////////////////////////////////////
  // Stage 1, product register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= rep_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && rep_valid) begin
      s1_prod <= acc_t'(rep_pixel) * acc_t'(rep_weight);
      s1_last <= rep_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2, accumulate and produce the result
  ////////////////////////////////////////////////////////////

  always_comb begin
    acc_sum   = acc_q + s1_prod;
    acc_shift = acc_sum >>> OUT_SHIFT;
    if (acc_shift > RES_MAX) begin
      sat_res = result_t'(RES_MAX);
    end else if (acc_shift < RES_MIN) begin
      sat_res = result_t'(RES_MIN);
    end else begin
      sat_res = result_t'(acc_shift);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q     <= '0;
      res_valid <= 1'b0;
    end else if (advance) begin
      res_valid <= 1'b0;
      if (s1_valid) begin
        if (s1_last) begin
          // Next beat starts a fresh sum
          acc_q     <= '0;
          res_valid <= 1'b1;
        end else begin
          acc_q <= acc_sum;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance && s1_valid && s1_last) begin
      res_data <= sat_res;
    end
  end

endmodule

// ==== hw/conv_1x1_layer.sv ====
module conv_1x1_layer
  import conv_geom_pkg::*;
  import conv_num_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    weight_valid,
  input  weight_t weight_data,
  input  logic    in_valid,
  output logic    in_ready,
  input  pixel_t  in_data,
  output logic    out_valid,
  input  logic    out_ready,
  output result_t out_data
);

  logic                loaded;
  logic                fifo_in_ready;
  logic                fifo_out_valid;
  logic                fifo_out_ready;
  pixel_t              fifo_out_data;
  logic [CH_IDX_W-1:0] out_ch;
  logic [CH_IDX_W-1:0] in_ch;
  weight_t             rd_weight;
  logic                rep_valid;
  logic                rep_ready;
  pixel_t              rep_pixel;
  weight_t             rep_weight;
  logic                rep_last;
  logic                res_valid;
  logic                res_ready;
  result_t             res_data;

  // Pixel port closed until the weight store is full
  assign in_ready = fifo_in_ready & loaded;

  stream_fifo #(
    .payload_t (pixel_t),
    .DEPTH     (FIFO_DEPTH)
  ) i_in_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid & loaded),
    .in_ready  (fifo_in_ready),
    .in_data   (in_data),
    .out_valid (fifo_out_valid),
    .out_ready (fifo_out_ready),
    .out_data  (fifo_out_data)
  );

  weight_store i_weight_store (
    .clk          (clk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .loaded       (loaded),
    .out_ch       (out_ch),
    .in_ch        (in_ch),
    .rd_weight    (rd_weight)
  );

  channel_replay i_channel_replay (
    .clk        (clk),
    .reset      (reset),
    .loaded     (loaded),
    .in_valid   (fifo_out_valid),
    .in_ready   (fifo_out_ready),
    .in_data    (fifo_out_data),
    .out_ch     (out_ch),
    .in_ch      (in_ch),
    .rd_weight  (rd_weight),
    .rep_valid  (rep_valid),
    .rep_ready  (rep_ready),
    .rep_pixel  (rep_pixel),
    .rep_weight (rep_weight),
    .rep_last   (rep_last)
  );

  mac_accumulator i_mac_accumulator (
    .clk        (clk),
    .reset      (reset),
    .rep_valid  (rep_valid),
    .rep_ready  (rep_ready),
    .rep_pixel  (rep_pixel),
    .rep_weight (rep_weight),
    .rep_last   (rep_last),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_data   (res_data)
  );

  // Replay order is already final order, one FIFO is enough
  stream_fifo #(
    .payload_t (result_t),
    .DEPTH     (FIFO_DEPTH)
  ) i_out_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (res_valid),
    .in_ready  (res_ready),
    .in_data   (res_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

// ==== sim/conv_1x1_checker.sv ====
module conv_1x1_checker
  import conv_geom_pkg::*;
  import conv_num_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input logic    weight_valid,
  input logic    in_ready,
  input logic    out_valid,
  input logic    out_ready,
  input result_t out_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int assert_failures = 0;

  // Weight words seen since reset
  int weights_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      weights_seen <= 0;
    end else if (weight_valid && weights_seen < WEIGHTS) begin
      weights_seen <= weights_seen + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reset behavior
  ////////////////////////////////////////////////////////////

  reset_out_valid: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high during reset");
      assert_failures++;
    end

  // One cycle past the falling edge of reset
  after_reset_out_valid: assert property (@(posedge clk) $fell(reset) |=> !out_valid)
    else begin
      $error("out_valid high one cycle after reset");
      assert_failures++;
    end

  ////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////

  out_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      $error("out_data or out_valid changed while stalled");
      assert_failures++;
    end

  // Pixel port stays closed until the whole weight stream is in
  ready_gate: assert property (@(posedge clk) disable iff (reset)
    weights_seen < WEIGHTS |-> !in_ready)
    else begin
      $error("in_ready high before all weights arrived");
      assert_failures++;
    end

endmodule

// ==== sim/conv_1x1_tb.sv ====
module conv_1x1_tb
  import conv_geom_pkg::*;
  import conv_num_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int SEED         = 10386;
  localparam int IMAGE_WORDS  = PIXELS * CH_IN;
  localparam int IMAGE_BEATS  = PIXELS * CH_OUT;
  // Bound per image covers its weights, input words and replay beats
  localparam int N_IMAGES     = 4;
  localparam int IMAGE_CYCLES = WEIGHTS + IMAGE_WORDS + IMAGE_BEATS * CH_IN;
  localparam int MARGIN       = 8;
  localparam int WATCHDOG_CYCLES = N_IMAGES * IMAGE_CYCLES * MARGIN;
  localparam int STALL_LIMIT  = 400;

  logic    clk = 1'b0;
  logic    reset;
  logic    weight_valid;
  weight_t weight_data;
  logic    in_valid;
  logic    in_ready;
  pixel_t  in_data;
  logic    out_valid;
  logic    out_ready;
  result_t out_data;

  pixel_t  image [IMAGE_WORDS];
  weight_t weights [WEIGHTS];
  result_t expected_q [$];
  logic    saw_stall;

  // Separate streams keep stimulus independent of process order
  logic [31:0] rng_data  = 32'(SEED);
  logic [31:0] rng_feed  = 32'(SEED * 3);
  logic [31:0] rng_ready = 32'(SEED * 7);

  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;

  conv_1x1_layer i_conv_1x1_layer (
    .clk          (clk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data)
  );

  bind conv_1x1_layer conv_1x1_checker i_conv_1x1_checker (
    .clk          (clk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Sum over input channels, arithmetic shift, clamp to 16 bits
  function automatic result_t expected_value(input int pix, input int oc);
    int sum;
    sum = 0;
    for (int ic = 0; ic < CH_IN; ic++) begin
      sum += int'(image[pix * CH_IN + ic]) * int'(weights[oc * CH_IN + ic]);
    end
    sum = sum >>> OUT_SHIFT;
    if (sum > int'(RES_MAX)) begin
      sum = int'(RES_MAX);
    end else if (sum < int'(RES_MIN)) begin
      sum = int'(RES_MIN);
    end
    return result_t'(sum);
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare and report
  ////////////////////////////////////////////////////////////

  task automatic compare_result(input result_t got, input result_t exp, input string what);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    other_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  function automatic int error_total();
    return mismatches + other_errors + i_conv_1x1_layer.i_conv_1x1_checker.assert_failures;
  endfunction

  task automatic print_summary();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
             checks, mismatches, other_errors,
             i_conv_1x1_layer.i_conv_1x1_checker.assert_failures);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers entered just after a rising edge
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    reset        <= 1'b1;
    weight_valid <= 1'b0;
    in_valid     <= 1'b0;
    out_ready    <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic randomize_image();
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      rng_data = xorshift32(rng_data);
      image[i] = pixel_t'(rng_data);
    end
  endtask

  task automatic randomize_weights();
    for (int i = 0; i < WEIGHTS; i++) begin
      rng_data   = xorshift32(rng_data);
      weights[i] = weight_t'(rng_data);
    end
  endtask

  task automatic queue_model_results();
    for (int p = 0; p < PIXELS; p++) begin
      for (int oc = 0; oc < CH_OUT; oc++) begin
        expected_q.push_back(expected_value(p, oc));
      end
    end
  endtask

  task automatic load_weights();
    for (int i = 0; i < WEIGHTS; i++) begin
      weight_valid <= 1'b1;
      weight_data  <= weights[i];
      @(posedge clk);
    end
    weight_valid <= 1'b0;
  endtask

  task automatic feed_image(input bit gaps);
    logic accepted;
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      rng_feed = xorshift32(rng_feed);
      if (gaps && rng_feed[1:0] == 2'b00) begin
        in_valid <= 1'b0;
        repeat (int'(rng_feed[3:2]) + 1) @(posedge clk);
      end
      in_valid <= 1'b1;
      in_data  <= image[i];
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = in_ready;
        @(posedge clk);
      end
    end
    in_valid <= 1'b0;
  endtask

  task automatic drain_results(input int count, input bit random_ready);
    int got;
    got = 0;
    while (got < count) begin
      rng_ready = xorshift32(rng_ready);
      out_ready <= random_ready ? rng_ready[0] : 1'b1;
      @(negedge clk);
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          report_error("a result arrived with no expected value left");
        end else begin
          compare_result(out_data, expected_q.pop_front(), $sformatf("result %0d", got));
        end
        got++;
      end
      @(posedge clk);
    end
    out_ready <= 1'b0;
  endtask

  task automatic watch_stall(output logic seen);
    seen = 1'b0;
    for (int i = 0; i < STALL_LIMIT && !seen; i++) begin
      @(negedge clk);
      if (in_valid && !in_ready) begin
        seen = 1'b1;
      end
      @(posedge clk);
    end
  endtask

  // No extra results and nothing left unmatched
  task automatic close_image(input string name);
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare_flag(out_valid, 1'b0, {name, ": out_valid after last result"});
    if (expected_q.size() != 0) begin
      report_error($sformatf("%s: %0d expected results never arrived", name, expected_q.size()));
      expected_q.delete();
    end
    @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    apply_reset();
    @(negedge clk);
    compare_flag(out_valid, 1'b0, "out_valid after reset");
    compare_flag(in_ready, 1'b0, "in_ready after reset");
    @(posedge clk);
    in_valid <= 1'b1;
    in_data  <= pixel_t'(8'h5a);
    repeat (8) begin
      @(negedge clk);
      compare_flag(in_ready, 1'b0, "in_ready before weights");
      compare_flag(out_valid, 1'b0, "out_valid before weights");
      @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  task automatic test_identity();
    apply_reset();
    for (int oc = 0; oc < CH_OUT; oc++) begin
      for (int ic = 0; ic < CH_IN; ic++) begin
        weights[oc * CH_IN + ic] = (oc == ic) ? weight_t'(1 << OUT_SHIFT) : weight_t'(0);
      end
    end
    randomize_image();
    // Scale and shift cancel so each output is its own channel's pixel
    for (int p = 0; p < PIXELS; p++) begin
      for (int oc = 0; oc < CH_OUT; oc++) begin
        expected_q.push_back(result_t'(image[p * CH_IN + oc]));
      end
    end
    load_weights();
    fork
      feed_image(1'b0);
      drain_results(IMAGE_BEATS, 1'b0);
    join
    close_image("identity");
  endtask

  task automatic test_random_image();
    apply_reset();
    randomize_weights();
    randomize_image();
    queue_model_results();
    load_weights();
    fork
      feed_image(1'b0);
      drain_results(IMAGE_BEATS, 1'b0);
    join
    close_image("random image");
  endtask

  task automatic test_saturation();
    apply_reset();
    for (int i = 0; i < WEIGHTS; i++) begin
      weights[i] = ((i / CH_IN) % 2 == 0) ? weight_t'(-128) : weight_t'(127);
    end
    for (int i = 0; i < IMAGE_WORDS; i++) begin
      image[i] = ((i / CH_IN) % 2 == 0) ? pixel_t'(-128) : pixel_t'(127);
    end
    queue_model_results();
    load_weights();
    fork
      feed_image(1'b0);
      drain_results(IMAGE_BEATS, 1'b0);
    join
    close_image("saturation");
  endtask

  task automatic test_backpressure();
    apply_reset();
    randomize_weights();
    randomize_image();
    queue_model_results();
    load_weights();
    // Output held until the input side backs up
    fork
      feed_image(1'b1);
      begin
        watch_stall(saw_stall);
        drain_results(IMAGE_BEATS, 1'b1);
      end
    join
    compare_flag(saw_stall, 1'b1, "in_ready fell while output stalled");
    close_image("backpressure");
  endtask

  initial begin
    reset        = 1'b1;
    weight_valid = 1'b0;
    weight_data  = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b0;
    test_reset_state();
    test_identity();
    test_random_image();
    test_saturation();
    test_backpressure();
    print_summary();
    if (error_total() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    print_summary();
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== tb.f ====
hw/conv_geom_pkg.sv
hw/conv_num_pkg.sv
hw/stream_fifo.sv
hw/weight_store.sv
hw/channel_replay.sv
hw/mac_accumulator.sv
hw/conv_1x1_layer.sv
sim/conv_1x1_checker.sv
sim/conv_1x1_tb.sv

// ==== Makefile ====
# Verilator build and run of the 1x1 convolution testbench

VERILATOR ?= verilator
TOP       ?= conv_1x1_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
